// File: cpuCore.f
source/cpuPkg.sv
source/fetchStage.sv
source/controlDecoder.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/cpuCore.sv
testbench/cpuCoreTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpuCore.f --top-module cpuCoreTb \
   --Mdir obj_dir -o cpuCoreSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
   echo "Simulation reported failure"
   exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: source/controlDecoder.sv
// Control decoder
`default_nettype none
module controlDecoder (
   input  cpuPkg::instrWord instr,
   output cpuPkg::ctrlT     ctrl
);
   import cpuPkg::*;

   always_comb begin
      // Defaults give a NOP.
      ctrl       = '0;
      ctrl.aluOp = aluAdd;
      ctrl.wrSel = wrSelR;
      case (instr.rView.opcode)
         opHalt: ctrl.halt = 1'b1;
         opNop: ;
         ////////////////////////////////////////
         // Immediate ALU ops.
         ////////////////////////////////////////
         opAddi, opSubi, opXori, opAndni: begin
            ctrl.regWrite = 1'b1;
            ctrl.useImm   = 1'b1;
            ctrl.wrSel    = wrSelI;
            // Logical ops take imm5 unsigned.
            ctrl.zeroExt  = instr.rView.opcode[1];
            case (instr.rView.opcode[1:0])
               2'b00:   ctrl.aluOp = aluAdd;
               2'b01:   ctrl.aluOp = aluSub;
               2'b10:   ctrl.aluOp = aluXor;
               default: ctrl.aluOp = aluAndn;
            endcase
         end
         opLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.useImm   = 1'b1;
            ctrl.aluOp    = aluPassB;    // Just the sign-extended imm8.
            ctrl.wrSel    = wrSelB;
         end
         opBeqz: begin
            ctrl.isBranch     = 1'b1;
            ctrl.branchOnZero = 1'b1;
         end
         opBnez: ctrl.isBranch = 1'b1;
         opJ:    ctrl.isJump = 1'b1;
         opJal: begin
            ctrl.isJump   = 1'b1;
            ctrl.link     = 1'b1;      // Writes PC+2.
            ctrl.regWrite = 1'b1;
            ctrl.wrSel    = wrSelLink;
         end
         opJr: begin
            ctrl.isJump = 1'b1;
            ctrl.isJr   = 1'b1;
         end
         opRtype: begin
            ctrl.regWrite = 1'b1;
            case (instr.rView.func)
               fnAdd:   ctrl.aluOp = aluAdd;
               fnSub:   ctrl.aluOp = aluSub;
               fnXor:   ctrl.aluOp = aluXor;
               fnAndn:  ctrl.aluOp = aluAndn;
               default: ctrl.aluOp = aluAdd;
            endcase
         end
         default: ;                    // Unknown, treated as NOP.
      endcase
   end

endmodule
`default_nettype wire

// File: source/cpuCore.sv
// Single-cycle core top
`default_nettype none
module cpuCore (
   input  logic clk,
   input  logic rst,
   input  logic progWe,
   input  logic [cpuPkg::imemAddrW-1:0] progAddr,
   input  logic [cpuPkg::dataWidth-1:0] progData,
   output logic halted,
   output cpuPkg::commitT commit
);
   import cpuPkg::*;

   fetchOutT fetchOut;
   decodeOutT decodeOut;
   wbT wb;
   logic [dataWidth-1:0] nextPc;
   logic halt;

   fetchStage iFetch (
      .clk(clk), .rst(rst),
      .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .nextPc(nextPc), .halt(halt), .halted(halted),
      .fetchOut(fetchOut)
   );

   // Decode feeds PC back and takes write-back.
   decodeStage iDecode (
      .clk(clk), .rst(rst),
      .fetchIn(fetchOut), .wb(wb),
      .nextPc(nextPc), .halt(halt), .decodeOut(decodeOut)
   );

   executeStage iExecute (
      .clk(clk), .rst(rst), .halted(halted),
      .decodeIn(decodeOut), .wb(wb), .commit(commit)
   );

endmodule
`default_nettype wire

// File: source/cpuPkg.sv
// Core shared definitions
`default_nettype none
package cpuPkg;

   ////////////////////////////////////////
   // Sizes.
   ////////////////////////////////////////
   localparam int dataWidth = 16;                // Machine word.
   localparam int regCount  = 8;
   localparam int regAddrW  = $clog2(regCount);
   localparam int imemDepth = 256;               // Words, PC steps by 2.
   localparam int imemAddrW = $clog2(imemDepth);
   localparam logic [regAddrW-1:0] linkReg = 3'd7;

   // Opcodes, bits 15:11.
   localparam logic [4:0] opHalt  = 5'b00000;
   localparam logic [4:0] opNop   = 5'b00001;
   localparam logic [4:0] opJ     = 5'b00100;
   localparam logic [4:0] opJr    = 5'b00101;
   localparam logic [4:0] opJal   = 5'b00110;
   localparam logic [4:0] opAddi  = 5'b01000;
   localparam logic [4:0] opSubi  = 5'b01001;
   localparam logic [4:0] opXori  = 5'b01010;
   localparam logic [4:0] opAndni = 5'b01011;
   localparam logic [4:0] opBeqz  = 5'b01100;
   localparam logic [4:0] opBnez  = 5'b01101;
   localparam logic [4:0] opLbi   = 5'b11000;
   localparam logic [4:0] opRtype = 5'b11011;

   // R-type function codes.
   localparam logic [1:0] fnAdd  = 2'b00;
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnXor  = 2'b10;
   localparam logic [1:0] fnAndn = 2'b11;

   // Destination register select.
   localparam logic [1:0] wrSelR    = 2'd0;    // rd of R view.
   localparam logic [1:0] wrSelI    = 2'd1;    // rd of I view.
   localparam logic [1:0] wrSelB    = 2'd2;    // rs, used by LBI.
   localparam logic [1:0] wrSelLink = 2'd3;    // r7.

   typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluAndn, aluPassB} aluOpT;

   ////////////////////////////////////////
   // Instruction word views.
   ////////////////////////////////////////
   typedef union packed {
      struct packed {logic [4:0] opcode; logic [2:0] rs, rt, rd; logic [1:0] func;} rView;
      struct packed {logic [4:0] opcode; logic [2:0] rs, rd; logic [4:0] imm5;} iView;
      struct packed {logic [4:0] opcode; logic [2:0] rs; logic [7:0] imm8;} bView;
      struct packed {logic [4:0] opcode; logic [10:0] disp11;} jView;
   } instrWord;

   typedef struct packed {
      logic halt, regWrite, useImm, zeroExt;
      logic isBranch, branchOnZero, isJump, isJr, link;
      aluOpT aluOp;
      logic [1:0] wrSel;
   } ctrlT;

   typedef struct packed {instrWord instr; logic [dataWidth-1:0] pc;} fetchOutT;

   typedef struct packed {
      ctrlT ctrl;
      logic [dataWidth-1:0] opA, opB, imm;
      logic [regAddrW-1:0] dest;
      logic [dataWidth-1:0] pc;
   } decodeOutT;

   typedef struct packed {logic en; logic [regAddrW-1:0] regIdx; logic [dataWidth-1:0] data;} wbT;

   typedef struct packed {
      logic valid;
      logic [dataWidth-1:0] pc;
      logic regWrite;
      logic [regAddrW-1:0] regIdx;
      logic [dataWidth-1:0] data;
   } commitT;

endpackage
`default_nettype wire

// File: source/decodeStage.sv
// Instruction decode
`default_nettype none
module decodeStage (
   input  logic clk,
   input  logic rst,
   input  cpuPkg::fetchOutT fetchIn,
   input  cpuPkg::wbT wb,
   output logic [cpuPkg::dataWidth-1:0] nextPc,
   output logic halt,
   output cpuPkg::decodeOutT decodeOut
);
   import cpuPkg::*;

   instrWord instr;
   ctrlT ctrl;
   logic [dataWidth-1:0] rdDataA, rdDataB, imm, pcPlus2;
   logic [regAddrW-1:0] destReg;
   logic taken;

   assign instr = fetchIn.instr;

   controlDecoder iCtrl (.instr(instr), .ctrl(ctrl));

   // rs and rt sit in the same bits in every view.
   regFile iRegFile (
      .clk(clk), .rst(rst),
      .rdRegA(instr.rView.rs), .rdRegB(instr.rView.rt),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .wb(wb)
   );

   ////////////////////////////////////////
   // Immediate and destination.
   ////////////////////////////////////////
   always_comb begin
      if (ctrl.isJump && !ctrl.isJr)      // J, JAL.
         imm = {{(dataWidth-11){instr.jView.disp11[10]}}, instr.jView.disp11};
      else if (ctrl.isBranch || ctrl.isJr || ctrl.aluOp == aluPassB)
         imm = {{(dataWidth-8){instr.bView.imm8[7]}}, instr.bView.imm8};
      else if (ctrl.zeroExt)
         imm = {{(dataWidth-5){1'b0}}, instr.iView.imm5};
      else
         imm = {{(dataWidth-5){instr.iView.imm5[4]}}, instr.iView.imm5};
      case (ctrl.wrSel)
         wrSelI:  destReg = instr.iView.rd;
         wrSelB:  destReg = instr.bView.rs;  // LBI target.
         wrSelLink: destReg = linkReg;
         default: destReg = instr.rView.rd;
      endcase
   end

   // Next PC resolved here, not in execute.
   assign pcPlus2 = fetchIn.pc + dataWidth'(2);
   assign taken   = ctrl.isBranch && ((rdDataA == '0) == ctrl.branchOnZero);

   always_comb begin
      if (ctrl.isJr)                  nextPc = rdDataA + imm;
      else if (ctrl.isJump || taken)  nextPc = pcPlus2 + imm;
      else                            nextPc = pcPlus2;
   end

   assign halt = ctrl.halt;

   assign decodeOut.ctrl = ctrl;
   assign decodeOut.opA  = rdDataA;
   assign decodeOut.opB  = rdDataB;
   assign decodeOut.imm  = imm;
   assign decodeOut.dest = destReg;
   assign decodeOut.pc   = fetchIn.pc;

   brJmpExcl: assert property (@(posedge clk) disable iff (rst) !(ctrl.isBranch && ctrl.isJump))
      else $error("decode: branch and jump both set");

endmodule
`default_nettype wire

// File: source/executeStage.sv
// Execute and commit
`default_nettype none
module executeStage (
   input  logic clk,
   input  logic rst,
   input  logic halted,
   input  cpuPkg::decodeOutT decodeIn,
   output cpuPkg::wbT wb,
   output cpuPkg::commitT commit
);
   import cpuPkg::*;

   logic [dataWidth-1:0] aluB, aluOut, wbData;

   ////////////////////////////////////////
   // ALU.
   ////////////////////////////////////////
   always_comb begin
      aluB = decodeIn.ctrl.useImm ? decodeIn.imm : decodeIn.opB;
      case (decodeIn.ctrl.aluOp)
         aluAdd:   aluOut = decodeIn.opA + aluB;
         aluSub:   aluOut = decodeIn.opA - aluB;  // rs minus rt or imm.
         aluXor:   aluOut = decodeIn.opA ^ aluB;
         aluAndn:  aluOut = decodeIn.opA & ~aluB;
         aluPassB: aluOut = aluB;
         default:  aluOut = decodeIn.opA + aluB;
      endcase
   end

   // JAL writes the return address.
   assign wbData = decodeIn.ctrl.link ? decodeIn.pc + dataWidth'(2) : aluOut;

   assign wb.en     = decodeIn.ctrl.regWrite;
   assign wb.regIdx = decodeIn.dest;
   assign wb.data   = wbData;

   ////////////////////////////////////////
   // Commit record, one cycle behind.
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) commit.valid <= 1'b0;
      else     commit.valid <= !halted;    // HALT itself still commits.
   end

   always_ff @(posedge clk) begin
      commit.pc       <= decodeIn.pc;
      commit.regWrite <= wb.en;
      commit.regIdx   <= wb.regIdx;
      commit.data     <= wbData;
   end

   // Halt is sticky in fetch, so commits stay off.
   quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
      halted |=> halted && !commit.valid)
      else $error("execute: commit after halt");

endmodule
`default_nettype wire

// File: source/fetchStage.sv
// Instruction fetch
`default_nettype none
module fetchStage (
   input  logic clk,
   input  logic rst,
   input  logic progWe,
   input  logic [cpuPkg::imemAddrW-1:0] progAddr,
   input  logic [cpuPkg::dataWidth-1:0] progData,
   input  logic [cpuPkg::dataWidth-1:0] nextPc,
   input  logic halt,
   output logic halted,
   output cpuPkg::fetchOutT fetchOut
);
   import cpuPkg::*;

   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] imem [imemDepth];

   // Program load. Only while held in reset.
   always_ff @(posedge clk) begin
      if (rst && progWe) begin
         imem[progAddr] <= progData;
      end
   end

   ////////////////////////////////////////
   // PC and halt freeze.
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else begin
         if (halt) halted <= 1'b1;         // Sticky until reset.
         if (!halt && !halted) begin
            pc <= nextPc;
         end
      end
   end

   // Word index is the byte PC without bit 0.
   assign fetchOut.instr = imem[pc[imemAddrW:1]];
   assign fetchOut.pc    = pc;

   pcEven: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
      else $error("fetch: odd PC %h", pc);

endmodule
`default_nettype wire

// File: source/regFile.sv
// Register file
`default_nettype none
module regFile (
   input  logic clk,
   input  logic rst,
   input  logic [cpuPkg::regAddrW-1:0] rdRegA,
   input  logic [cpuPkg::regAddrW-1:0] rdRegB,
   output logic [cpuPkg::dataWidth-1:0] rdDataA,
   output logic [cpuPkg::dataWidth-1:0] rdDataB,
   input  cpuPkg::wbT wb
);
   import cpuPkg::*;

   logic [dataWidth-1:0] regs [regCount];

   // One write port, lands at end of cycle.
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.en) begin
         regs[wb.regIdx] <= wb.data;
      end
   end

   // Asynchronous reads.
   assign rdDataA = regs[rdRegA];
   assign rdDataB = regs[rdRegB];

endmodule
`default_nettype wire

// File: testbench/cpuCoreTb.sv
// Core testbench
`default_nettype none
module cpuCoreTb;
   timeunit 1ns;
   timeprecision 1ps;
   import cpuPkg::*;

   logic clk, rst, progWe, halted;
   logic [imemAddrW-1:0] progAddr;
   logic [dataWidth-1:0] progData;
   commitT commit;

   logic [15:0] progMem [16];            // Testbench copy of the program.
   logic [15:0] mPc;                     // Model PC.
   logic [15:0] mRegs [8];
   logic [15:0] ir, srcA, srcB, sx5, zx5, sx8, sx11, seqPc;
   logic [15:0] expData, expNext;
   logic [2:0] expIdx;
   logic expWe, expHalt;
   int checkErrors = 0;
   int timeoutErrors = 0;
   int commitCount = 0;
   int cycleCount = 0;
   int waited;
   integer seed;
   logic [31:0] rnd;

   cpuCore i_dut (
      .clk(clk), .rst(rst),
      .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .halted(halted), .commit(commit)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;            // 20 ns period.
   end

   always @(posedge clk) cycleCount <= cycleCount + 1;

   // Instruction encoders.
   function automatic logic [15:0] rtypeWord(input logic [2:0] rs, rt, rd,
                                             input logic [1:0] fn);
      return {opRtype, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] immWord(input logic [4:0] op, input logic [2:0] rs, rd,
                                           input logic [4:0] imm5);
      return {op, rs, rd, imm5};
   endfunction

   function automatic logic [15:0] branchWord(input logic [4:0] op, input logic [2:0] rs,
                                              input logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic logic [15:0] jumpWord(input logic [4:0] op, input logic [10:0] disp);
      return {op, disp};
   endfunction

   ////////////////////////////////////////
   // Reference ISA model.
   ////////////////////////////////////////
   always_comb begin
      ir    = progMem[mPc[4:1]];
      srcA  = mRegs[ir[10:8]];
      srcB  = mRegs[ir[7:5]];
      sx5   = {{11{ir[4]}}, ir[4:0]};
      zx5   = {11'b0, ir[4:0]};
      sx8   = {{8{ir[7]}}, ir[7:0]};
      sx11  = {{5{ir[10]}}, ir[10:0]};
      seqPc = mPc + 16'd2;
      expWe   = 1'b0;
      expIdx  = ir[7:5];                 // I-type rd by default.
      expData = 16'd0;
      expNext = seqPc;
      expHalt = 1'b0;
      case (ir[15:11])
         opHalt: begin
            expHalt = 1'b1;
            expNext = mPc;
         end
         opRtype: begin
            expWe  = 1'b1;
            expIdx = ir[4:2];
            case (ir[1:0])
               fnAdd:   expData = srcA + srcB;
               fnSub:   expData = srcA - srcB;
               fnXor:   expData = srcA ^ srcB;
               default: expData = srcA & ~srcB;
            endcase
         end
         opAddi: begin
            expWe   = 1'b1;
            expData = srcA + sx5;
         end
         opSubi: begin
            expWe   = 1'b1;
            expData = srcA - sx5;
         end
         opXori: begin
            expWe   = 1'b1;
            expData = srcA ^ zx5;        // Unsigned imm.
         end
         opAndni: begin
            expWe   = 1'b1;
            expData = srcA & ~zx5;
         end
         opLbi: begin
            expWe   = 1'b1;
            expIdx  = ir[10:8];
            expData = sx8;
         end
         opBeqz: if (srcA == 16'd0) expNext = seqPc + sx8;
         opBnez: if (srcA != 16'd0) expNext = seqPc + sx8;
         opJ:    expNext = seqPc + sx11;
         opJal: begin
            expNext = seqPc + sx11;
            expWe   = 1'b1;
            expIdx  = 3'd7;              // Link register.
            expData = seqPc;
         end
         opJr:    expNext = srcA + sx8;
         default: ;
      endcase
   end

   // Model steps once per valid commit.
   always @(posedge clk) begin
      if (rst) begin
         mPc <= 16'd0;
         for (int i = 0; i < 8; i++) begin
            mRegs[i] <= 16'd0;
         end
      end else if (commit.valid) begin
         if (expWe) mRegs[expIdx] <= expData;
         mPc <= expNext;
         commitCount <= commitCount + 1;
      end
   end

   ////////////////////////////////////////
   // Checks against the model.
   ////////////////////////////////////////
   resetQuiet: assert property (@(posedge clk)
      (rst && cycleCount > 1) |-> !commit.valid && !halted)
      else begin
         checkErrors++;
         $display("FAILED %0t: commit or halted active during reset", $time);
      end

   commitPc: assert property (@(posedge clk) disable iff (rst)
      commit.valid |-> commit.pc == mPc)
      else begin
         checkErrors++;
         $display("FAILED %0t: commit PC %h, model PC %h", $time, $sampled(commit.pc),
                  $sampled(mPc));
      end

   commitWe: assert property (@(posedge clk) disable iff (rst)
      commit.valid |-> commit.regWrite == expWe)
      else begin
         checkErrors++;
         $display("FAILED %0t: regWrite %b at PC %h", $time, $sampled(commit.regWrite),
                  $sampled(mPc));
      end

   commitData: assert property (@(posedge clk) disable iff (rst)
      (commit.valid && expWe) |-> commit.regIdx == expIdx && commit.data == expData)
      else begin
         checkErrors++;
         $display("FAILED %0t: r%0d=%h, model r%0d=%h", $time, $sampled(commit.regIdx),
                  $sampled(commit.data), $sampled(expIdx), $sampled(expData));
      end

   haltRises: assert property (@(posedge clk) disable iff (rst)
      (commit.valid && expHalt) |-> halted)
      else begin
         checkErrors++;
         $display("FAILED %0t: HALT committed but halted is low", $time);
      end

   // Halted may only rise together with the model's HALT commit.
   haltCommits: assert property (@(posedge clk) disable iff (rst)
      $rose(halted) |-> commit.valid && expHalt)
      else begin
         checkErrors++;
         $display("FAILED %0t: halted rose without a HALT commit at model PC %h", $time,
                  $sampled(mPc));
      end

   quietHalted: assert property (@(posedge clk) disable iff (rst)
      $past(halted) |-> !commit.valid)
      else begin
         checkErrors++;
         $display("FAILED %0t: commit valid after halt", $time);
      end

   ////////////////////////////////////////
   // Stimulus.
   ////////////////////////////////////////
   initial begin
      rst      = 1'b1;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      seed     = 4913;
      rnd      = $random(seed);
      progMem[0]  = branchWord(opLbi, 3'd1, rnd[7:0] | 8'h01);   // r1 never zero.
      progMem[1]  = branchWord(opLbi, 3'd2, rnd[15:8]);
      progMem[2]  = rtypeWord(3'd1, 3'd2, 3'd3, fnAdd);
      progMem[3]  = rtypeWord(3'd1, 3'd2, 3'd4, fnSub);
      progMem[4]  = rtypeWord(3'd1, 3'd2, 3'd5, fnXor);
      progMem[5]  = rtypeWord(3'd1, 3'd2, 3'd6, fnAndn);
      progMem[6]  = immWord(opAddi, 3'd1, 3'd3, rnd[20:16] | 5'h10);  // Negative.
      progMem[7]  = immWord(opSubi, 3'd2, 3'd4, rnd[25:21]);
      rnd = $random(seed);
      progMem[8]  = immWord(opXori, 3'd1, 3'd5, rnd[4:0] | 5'h10);   // Top bit set.
      progMem[9]  = immWord(opAndni, 3'd2, 3'd6, rnd[9:5]);
      // Branch block runs twice. JAL sets r7 before the second pass.
      progMem[10] = branchWord(opBeqz, 3'd7, 8'd2);
      progMem[11] = jumpWord(opJ, 11'd0);
      progMem[12] = branchWord(opBnez, 3'd7, 8'd4);
      progMem[13] = jumpWord(opJal, 11'h7F8);                  // Back to PC 20.
      progMem[14] = jumpWord(opHalt, 11'd0);
      progMem[15] = branchWord(opJr, 3'd7, 8'd0);              // To HALT at 28.
      for (int i = 0; i < 16; i++) begin
         progWe   = 1'b1;
         progAddr = imemAddrW'(i);
         progData = progMem[i];
         @(negedge clk);
      end
      progWe = 1'b0;
      rst    = 1'b0;                     // After 16 rising edges.

      waited = 0;
      while (!halted && waited < 200) begin
         @(negedge clk);
         waited++;
      end
      if (!halted) begin
         timeoutErrors++;
         $display("Timeout: the core did not halt within 200 cycles");
      end

      // Commits must stay off while halted.
      repeat (20) @(negedge clk);

      $display("Errors: checks %0d, timeouts %0d, commits %0d",
               checkErrors, timeoutErrors, commitCount);
      if (checkErrors == 0 && timeoutErrors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
`default_nettype wire
